// File: src/fetch_pkg.sv
package fetch_pkg;

    // address geometry
    localparam int pc_width     = 32;
    localparam int tag_width    = 20;
    localparam int index_width  = 8;
    localparam int offset_width = 4;

    // fixed fetch addresses
    localparam logic [pc_width-1:0] reset_pc   = 32'hbfc0_0000;
    localparam logic [pc_width-1:0] exc_vector = 32'hbfc0_0380;

    // top three address bits of the unmapped kernel segments
    localparam logic [2:0] kseg0_top = 3'b100;
    localparam logic [2:0] kseg1_top = 3'b101;

    // redirect priority, larger value wins
    typedef logic [1:0] redir_prio_t;

    localparam redir_prio_t prio_none   = 2'd0;
    localparam redir_prio_t prio_branch = 2'd1;
    localparam redir_prio_t prio_flush  = 2'd2;
    localparam redir_prio_t prio_eret   = 2'd3;

    // branch result from decode
    typedef struct packed {
        logic                br_taken;
        logic                br_stall;   // decode not ready, ignore this cycle
        logic [pc_width-1:0] br_target;
    } br_bus_t;

    typedef logic [31:0] inst_t;

endpackage

// File: src/fetch_handoff_if.sv
interface fetch_handoff_if
    import fetch_pkg::*;
();

    logic                req_fire;    // request accepted, or address error issued
    logic [pc_width-1:0] req_pc;      // virtual pc of that fetch
    logic                req_adel;    // misaligned, no cache access
    logic                req_cancel;  // overtaken by flush/eret before acceptance
    logic                fs_allowin;  // if stage can take another fetch

    modport pre (
        output req_fire,
        output req_pc,
        output req_adel,
        output req_cancel,
        input  fs_allowin
    );

    modport fs (
        input  req_fire,
        input  req_pc,
        input  req_adel,
        input  req_cancel,
        output fs_allowin
    );

endinterface

// File: src/pre_if_stage.sv
module pre_if_stage
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  br_bus_t             br_bus,
    input  logic                flush,
    input  logic                eret,
    input  logic [pc_width-1:0] cp0_epc,
    input  logic                inst_addr_ok,
    output logic                inst_req,
    output logic [pc_width-1:0] req_vaddr,
    fetch_handoff_if.pre        handoff
);

    logic                started;     // first cycle out of reset has passed
    logic [pc_width-1:0] last_pc;     // last issued pc
    logic                holding;     // request raised, still waiting for addr_ok
    logic                hold_stale;  // flush/eret seen while holding
    redir_prio_t         pend_prio;
    logic [pc_width-1:0] pend_pc;

    redir_prio_t         evt_prio;
    logic [pc_width-1:0] evt_pc;
    redir_prio_t         pend_left;
    logic [pc_width-1:0] next_pc;
    logic                misaligned;
    logic                fetch_en;
    logic                launch;
    logic                accept;
    logic                adel_fire;
    logic                take;
    logic                evt_wins;

    // redirect event arriving this cycle
    always_comb begin
        evt_prio = prio_none;
        evt_pc   = br_bus.br_target;
        if (eret) begin
            evt_prio = prio_eret;
            evt_pc   = cp0_epc;
        end else if (flush) begin
            evt_prio = prio_flush;
            evt_pc   = exc_vector;
        end else if (br_bus.br_taken && !br_bus.br_stall) begin
            evt_prio = prio_branch;
        end
    end

    // a pending redirect always beats the sequential pc
    assign next_pc    = (pend_prio != prio_none) ? pend_pc : last_pc + pc_width'(4);
    assign misaligned = next_pc[1:0] != 2'b00;

    assign fetch_en  = started & handoff.fs_allowin;
    assign inst_req  = fetch_en & (holding | ~misaligned);
    assign req_vaddr = holding ? last_pc : next_pc;  // held address was latched at launch

    assign launch    = inst_req & ~holding;   // first cycle of a new request
    assign accept    = inst_req & inst_addr_ok;
    assign adel_fire = fetch_en & ~holding & misaligned;
    assign take      = launch | adel_fire;    // next_pc consumed this cycle

    // whatever was pending is gone once it is taken
    assign pend_left = take ? prio_none : pend_prio;
    assign evt_wins  = (evt_prio != prio_none) && (evt_prio >= pend_left);

    assign handoff.req_fire   = accept | adel_fire;
    assign handoff.req_pc     = req_vaddr;
    assign handoff.req_adel   = adel_fire;
    assign handoff.req_cancel = holding & hold_stale;

    always_ff @(posedge clk) begin
        if (reset) begin
            started    <= 1'b0;
            last_pc    <= reset_pc - pc_width'(4);  // so the first fetch lands on reset_pc
            holding    <= 1'b0;
            hold_stale <= 1'b0;
            pend_prio  <= prio_none;
        end else begin
            started <= 1'b1;

            if (take) begin
                last_pc <= next_pc;
            end

            if (accept) begin
                holding <= 1'b0;
            end else if (launch) begin
                holding <= 1'b1;
            end

            // the held request still completes, if stage throws its data away
            if (accept) begin
                hold_stale <= 1'b0;
            end else if ((holding | launch) & (flush | eret)) begin
                hold_stale <= 1'b1;
            end

            if (evt_wins) begin
                pend_prio <= evt_prio;
            end else if (take) begin
                pend_prio <= prio_none;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (evt_wins) begin
            pend_pc <= evt_pc;
        end
    end

    // cache sees one address per request until it takes it
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        inst_req && !inst_addr_ok |=> req_vaddr == $past(req_vaddr)
    );

endmodule

// File: src/addr_translate.sv
module addr_translate
    import fetch_pkg::*;
(
    input  logic [pc_width-1:0]     vaddr,
    output logic [tag_width-1:0]    inst_tag,
    output logic [index_width-1:0]  inst_index,
    output logic [offset_width-1:0] inst_offset,
    output logic                    inst_uncached
);

    logic [2:0]          seg;
    logic                in_kseg0;
    logic                in_kseg1;
    logic [pc_width-1:0] paddr;

    assign seg      = vaddr[pc_width-1 -: 3];
    assign in_kseg0 = seg == kseg0_top;
    assign in_kseg1 = seg == kseg1_top;

    // unmapped kernel segments fold onto the low 512M
    // everything else goes through as is, there is no tlb
    always_comb begin
        paddr = vaddr;
        if (in_kseg0 || in_kseg1) begin
            paddr[pc_width-1 -: 3] = 3'b000;
        end
    end

    assign inst_uncached = in_kseg1;

    // tag | index | offset, msb first
    assign inst_tag    = paddr[pc_width-1 -: tag_width];
    assign inst_index  = paddr[offset_width +: index_width];
    assign inst_offset = paddr[offset_width-1:0];

endmodule

// File: src/if_stage.sv
module if_stage
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                eret,
    input  logic                inst_data_ok,
    input  inst_t               inst_rdata,
    input  logic                ds_allowin,
    output logic                fs_valid,
    output logic                fs_adel,
    output logic [pc_width-1:0] fs_pc,
    output inst_t               fs_inst,
    fetch_handoff_if.fs         handoff
);

    logic                busy;     // one request outstanding at the cache
    logic [pc_width-1:0] busy_pc;
    logic                cancel;   // outstanding data is stale

    logic                kill;
    logic                new_req;
    logic                cur_cancel;
    logic [pc_width-1:0] resp_pc;
    logic                resp_ok;
    logic                adel_ok;
    logic                load;

    assign kill    = flush | eret;
    assign new_req = handoff.req_fire & ~handoff.req_adel;

    // data_ok may land in the very cycle the request is accepted
    assign cur_cancel = busy ? cancel : handoff.req_cancel;
    assign resp_pc    = busy ? busy_pc : handoff.req_pc;

    assign resp_ok = inst_data_ok & ~cur_cancel & ~kill;
    assign adel_ok = handoff.req_fire & handoff.req_adel & ~kill;
    assign load    = resp_ok | adel_ok;

    // no issue while waiting, or while decode holds a full register
    assign handoff.fs_allowin = ~busy & (~fs_valid | ds_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            cancel <= 1'b0;
        end else begin
            if (inst_data_ok) begin
                busy   <= 1'b0;
                cancel <= 1'b0;
            end else if (new_req) begin
                busy   <= 1'b1;
                cancel <= handoff.req_cancel | kill;
            end else if (busy & kill) begin
                cancel <= 1'b1;  // swallow the data_ok still on its way
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_req) begin
            busy_pc <= handoff.req_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (kill) begin
            fs_valid <= 1'b0;
        end else if (load) begin
            fs_valid <= 1'b1;
        end else if (ds_allowin) begin
            fs_valid <= 1'b0;
        end
    end

    // output payload, held until decode takes it
    always_ff @(posedge clk) begin
        if (load) begin
            fs_pc   <= adel_ok ? handoff.req_pc : resp_pc;
            fs_inst <= adel_ok ? '0 : inst_rdata;  // nop on address error
            fs_adel <= adel_ok;
        end
    end

    // every response must belong to a request accepted by the pre-IF stage
    a_no_orphan_data: assert property (
        @(posedge clk) disable iff (reset)
        inst_data_ok |-> busy || new_req
    );

endmodule

// File: src/fetch_frontend.sv
module fetch_frontend
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  br_bus_t                 br_bus,
    input  logic                    flush,
    input  logic                    eret,
    input  logic [pc_width-1:0]     cp0_epc,
    input  logic                    inst_addr_ok,
    input  logic                    inst_data_ok,
    input  inst_t                   inst_rdata,
    input  logic                    ds_allowin,
    output logic                    inst_req,
    output logic [tag_width-1:0]    inst_tag,
    output logic [index_width-1:0]  inst_index,
    output logic [offset_width-1:0] inst_offset,
    output logic                    inst_uncached,
    output logic                    fs_valid,
    output logic [pc_width-1:0]     fs_pc,
    output inst_t                   fs_inst,
    output logic                    fs_adel
);

    logic [pc_width-1:0] req_vaddr;

    fetch_handoff_if handoff ();

    pre_if_stage u_pre_if (
        .clk          (clk),
        .reset        (reset),
        .br_bus       (br_bus),
        .flush        (flush),
        .eret         (eret),
        .cp0_epc      (cp0_epc),
        .inst_addr_ok (inst_addr_ok),
        .inst_req     (inst_req),
        .req_vaddr    (req_vaddr),
        .handoff      (handoff.pre)
    );

    addr_translate u_translate (
        .vaddr         (req_vaddr),
        .inst_tag      (inst_tag),
        .inst_index    (inst_index),
        .inst_offset   (inst_offset),
        .inst_uncached (inst_uncached)
    );

    if_stage u_if (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .eret         (eret),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .ds_allowin   (ds_allowin),
        .fs_valid     (fs_valid),
        .fs_adel      (fs_adel),
        .fs_pc        (fs_pc),
        .fs_inst      (fs_inst),
        .handoff      (handoff.fs)
    );

endmodule

// File: testbench/icache_responder.sv
module icache_responder
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_req,
    input  logic [tag_width-1:0]    inst_tag,
    input  logic [index_width-1:0]  inst_index,
    input  logic [offset_width-1:0] inst_offset,
    output logic                    inst_addr_ok,
    output logic                    inst_data_ok,
    output inst_t                   inst_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    integer              seed;
    logic [31:0]         rnd;
    logic                have;        // accepted request waiting for its data
    logic [pc_width-1:0] held_paddr;
    logic [1:0]          addr_wait;   // cycles left before addr_ok
    logic [1:0]          data_wait;   // cycles left before data_ok
    logic                accept;

    initial begin
        seed = 40;
    end

    always @(posedge clk) begin
        if (reset) begin
            inst_addr_ok <= 1'b0;
            inst_data_ok <= 1'b0;
            inst_rdata   <= '0;
            have         = 1'b0;
            addr_wait    = 2'd0;
            data_wait    = 2'd0;
        end else begin
            inst_addr_ok <= 1'b0;
            inst_data_ok <= 1'b0;
            accept = inst_req && inst_addr_ok;
            if (accept) begin
                rnd        = $random(seed);
                have       = 1'b1;
                held_paddr = {inst_tag, inst_index, inst_offset};
                data_wait  = rnd[1:0];
                addr_wait  = rnd[3:2];  // delay for the next request
            end else if (have) begin
                if (data_wait == 2'd0) begin
                    inst_data_ok <= 1'b1;
                    inst_rdata   <= held_paddr ^ 32'h5a5a_5a5a;
                    have = 1'b0;
                end else begin
                    data_wait = data_wait - 2'd1;
                end
            end
            // addr_ok only toward a request that is up now
            if (inst_req && !accept && !have) begin
                if (addr_wait == 2'd0) begin
                    inst_addr_ok <= 1'b1;
                end else begin
                    addr_wait = addr_wait - 2'd1;
                end
            end
        end
    end

endmodule

// File: testbench/tb_fetch_frontend.sv
module tb_fetch_frontend
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_ops = 2000;

    typedef struct packed {
        logic [pc_width-1:0] pc;
        inst_t               inst;
        logic                adel;
    } fetch_out_t;

    logic clk;
    logic reset;
    br_bus_t br_bus;
    logic flush;
    logic eret;
    logic [pc_width-1:0] cp0_epc;
    logic inst_addr_ok;
    logic inst_data_ok;
    inst_t inst_rdata;
    logic ds_allowin;
    logic inst_req;
    logic [tag_width-1:0] inst_tag;
    logic [index_width-1:0] inst_index;
    logic [offset_width-1:0] inst_offset;
    logic inst_uncached;
    logic fs_valid;
    logic [pc_width-1:0] fs_pc;
    inst_t fs_inst;
    logic fs_adel;

    integer seed;
    int     consumed;
    logic   reset_applied;  // at least one reset edge has reached the DUT

    // reference model state
    fetch_out_t          expq[$];
    fetch_out_t          head;
    fetch_out_t          entry;
    logic                m_started;
    logic [pc_width-1:0] m_last;
    redir_prio_t         m_prio;
    logic [pc_width-1:0] m_pend;
    logic                m_hold;
    logic                m_hstale;
    logic                m_busy;
    logic [pc_width-1:0] m_busy_pc;
    logic                m_stale;

    fetch_frontend uut (
        .clk           (clk),
        .reset         (reset),
        .br_bus        (br_bus),
        .flush         (flush),
        .eret          (eret),
        .cp0_epc       (cp0_epc),
        .inst_addr_ok  (inst_addr_ok),
        .inst_data_ok  (inst_data_ok),
        .inst_rdata    (inst_rdata),
        .ds_allowin    (ds_allowin),
        .inst_req      (inst_req),
        .inst_tag      (inst_tag),
        .inst_index    (inst_index),
        .inst_offset   (inst_offset),
        .inst_uncached (inst_uncached),
        .fs_valid      (fs_valid),
        .fs_pc         (fs_pc),
        .fs_inst       (fs_inst),
        .fs_adel       (fs_adel)
    );

    icache_responder u_icache (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .inst_tag     (inst_tag),
        .inst_index   (inst_index),
        .inst_offset  (inst_offset),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // fixed segment mapping without a tlb
    function automatic logic [pc_width-1:0] to_phys(input logic [pc_width-1:0] va);
        logic [pc_width-1:0] pa;
        pa = va;
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
            pa[31:29] = 3'b000;
        end
        return pa;
    endfunction

    // address in kseg0, kseg1 or elsewhere and now and then misaligned
    function automatic logic [pc_width-1:0] pick_addr();
        logic [31:0] r;
        logic [31:0] a;
        r = $random(seed);
        a = $random(seed);
        if (r[1:0] == 2'd0) begin
            a[31:29] = 3'b100;
        end else if (r[1:0] == 2'd1) begin
            a[31:29] = 3'b101;
        end
        a[1:0] = (r[4:2] == 3'd0) ? {r[6], 1'b1} : 2'b00;
        return a;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        seed          = 40;
        consumed      = 0;
        reset_applied = 1'b0;
        reset         = 1'b1;
        br_bus        = '0;
        flush         = 1'b0;
        eret          = 1'b0;
        cp0_epc       = '0;
        ds_allowin    = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (consumed < n_ops) begin
            @(posedge clk);
        end
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(n_ops * 10 * 8);
        $display("timeout: fetched instructions stopped reaching decode");
        $display("TEST FAILED");
        $fatal(1);
    end

    // random decode and cp0 side
    always @(posedge clk) begin
        logic [31:0] rnd;
        if (!reset) begin
            rnd = $random(seed);
            flush      <= rnd[4:0] == 5'd0;
            eret       <= rnd[9:5] == 5'd1;
            ds_allowin <= rnd[11:10] != 2'd0;
            br_bus.br_taken  <= rnd[14:12] == 3'd0;
            br_bus.br_stall  <= rnd[15];
            br_bus.br_target <= pick_addr();
            cp0_epc          <= pick_addr();
        end
    end

    // model sees the same pre-edge values as the DUT flops
    always @(posedge clk) begin
        logic                fetch_en;
        logic [pc_width-1:0] nxt;
        logic [pc_width-1:0] req_pc;
        logic [pc_width-1:0] pa;
        logic                mis;
        logic                exp_req;
        logic                accept;
        logic                launch;
        logic                adel;
        logic                take;
        logic                kill;
        redir_prio_t         evt;
        logic [pc_width-1:0] evt_pc;
        redir_prio_t         pend_left;
        if (reset) begin
            expq.delete();
            m_started = 1'b0;
            m_last    = reset_pc - 32'd4;
            m_prio    = prio_none;
            m_pend    = '0;
            m_hold    = 1'b0;
            m_hstale  = 1'b0;
            m_busy    = 1'b0;
            m_stale   = 1'b0;
            // outputs are defined once the first reset edge has passed
            if (reset_applied) begin
                check_value("inst_req", 32'(inst_req), 32'd0);
                check_value("fs_valid", 32'(fs_valid), 32'd0);
            end
            reset_applied = 1'b1;
        end else begin
            check_value("fs_valid", 32'(fs_valid), 32'(expq.size() != 0));
            fetch_en = m_started && !m_busy && (expq.size() == 0 || ds_allowin);
            nxt      = (m_prio != prio_none) ? m_pend : m_last + 32'd4;
            mis      = nxt[1:0] != 2'b00;
            exp_req  = fetch_en && (m_hold || !mis);
            req_pc   = m_hold ? m_last : nxt;
            check_value("inst_req", 32'(inst_req), 32'(exp_req));
            if (exp_req) begin
                pa = to_phys(req_pc);
                check_value("inst_tag", 32'(inst_tag), 32'(pa[31:12]));
                check_value("inst_index", 32'(inst_index), 32'(pa[11:4]));
                check_value("inst_offset", 32'(inst_offset), 32'(pa[3:0]));
                check_value("inst_uncached", 32'(inst_uncached),
                            32'(req_pc[31:29] == 3'b101));
            end
            accept = exp_req && inst_addr_ok;
            launch = exp_req && !m_hold;
            adel   = fetch_en && !m_hold && mis;
            take   = launch || adel;
            kill   = flush || eret;

            if (expq.size() != 0) begin
                head = expq[0];
                check_value("fs_pc", fs_pc, head.pc);
                check_value("fs_adel", 32'(fs_adel), 32'(head.adel));
                if (!head.adel) begin
                    check_value("fs_inst", fs_inst, head.inst);
                end
                if (ds_allowin) begin
                    void'(expq.pop_front());
                    consumed++;
                end
            end
            if (kill) begin
                expq.delete();
            end

            if (inst_data_ok) begin
                if (!m_busy) begin
                    report_error("cache response arrived with no request outstanding");
                end
                if (!m_stale && !kill) begin
                    entry.pc   = m_busy_pc;
                    entry.inst = to_phys(m_busy_pc) ^ 32'h5a5a_5a5a;
                    entry.adel = 1'b0;
                    expq.push_back(entry);
                end
                m_busy  = 1'b0;
                m_stale = 1'b0;
            end else if (m_busy && kill) begin
                m_stale = 1'b1;
            end
            if (adel && !kill) begin
                entry.pc   = nxt;
                entry.inst = '0;
                entry.adel = 1'b1;
                expq.push_back(entry);
            end

            if (accept) begin
                m_busy    = 1'b1;
                m_busy_pc = req_pc;
                m_stale   = (m_hold && m_hstale) || kill;
                m_hold    = 1'b0;
                m_hstale  = 1'b0;
            end else if (launch) begin
                m_hold   = 1'b1;
                m_hstale = kill;
            end else if (m_hold && kill) begin
                m_hstale = 1'b1;
            end

            // one pending slot with priority eret > flush > branch
            evt    = prio_none;
            evt_pc = br_bus.br_target;
            if (eret) begin
                evt    = prio_eret;
                evt_pc = cp0_epc;
            end else if (flush) begin
                evt    = prio_flush;
                evt_pc = exc_vector;
            end else if (br_bus.br_taken && !br_bus.br_stall) begin
                evt = prio_branch;
            end
            pend_left = take ? prio_none : m_prio;
            if (evt != prio_none && evt >= pend_left) begin
                m_prio = evt;
                m_pend = evt_pc;
            end else if (take) begin
                m_prio = prio_none;
            end
            if (take) begin
                m_last = nxt;
            end
            m_started = 1'b1;
        end
    end

endmodule

// File: fetch_frontend.f
src/fetch_pkg.sv
src/fetch_handoff_if.sv
src/pre_if_stage.sv
src/addr_translate.sv
src/if_stage.sv
src/fetch_frontend.sv
testbench/icache_responder.sv
testbench/tb_fetch_frontend.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fetch_frontend
FILELIST  ?= fetch_frontend.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
